// File: rtl/corePkg.sv
package corePkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int aluWidth     = 4;
    localparam int srcWidth     = 2;
    localparam int funct3Width  = 3;
    localparam int fwdWidth     = 2;

    // alu operations.
    localparam logic [aluWidth-1:0] aluAdd   = 4'd0;
    localparam logic [aluWidth-1:0] aluSub   = 4'd1;
    localparam logic [aluWidth-1:0] aluAnd   = 4'd2;
    localparam logic [aluWidth-1:0] aluOr    = 4'd3;
    localparam logic [aluWidth-1:0] aluXor   = 4'd4;
    localparam logic [aluWidth-1:0] aluSll   = 4'd5;
    localparam logic [aluWidth-1:0] aluSrl   = 4'd6;
    localparam logic [aluWidth-1:0] aluSra   = 4'd7;
    localparam logic [aluWidth-1:0] aluSlt   = 4'd8;
    localparam logic [aluWidth-1:0] aluSltu  = 4'd9;
    localparam logic [aluWidth-1:0] aluPassB = 4'd10;

    // writeback source.
    localparam logic [srcWidth-1:0] resultAlu     = 2'd0;
    localparam logic [srcWidth-1:0] resultMem     = 2'd1;
    localparam logic [srcWidth-1:0] resultPcPlus4 = 2'd2;

    // load/store size, funct3 of the instruction.
    localparam logic [funct3Width-1:0] sizeByte  = 3'b000;
    localparam logic [funct3Width-1:0] sizeHalf  = 3'b001;
    localparam logic [funct3Width-1:0] sizeWord  = 3'b010;
    localparam logic [funct3Width-1:0] sizeByteU = 3'b100;
    localparam logic [funct3Width-1:0] sizeHalfU = 3'b101;

    // branch conditions share the same field.
    localparam logic [funct3Width-1:0] beq  = 3'b000;
    localparam logic [funct3Width-1:0] bne  = 3'b001;
    localparam logic [funct3Width-1:0] blt  = 3'b100;
    localparam logic [funct3Width-1:0] bge  = 3'b101;
    localparam logic [funct3Width-1:0] bltu = 3'b110;
    localparam logic [funct3Width-1:0] bgeu = 3'b111;

    localparam logic [fwdWidth-1:0] fwdNone = 2'd0;
    localparam logic [fwdWidth-1:0] fwdWb   = 2'd1;
    localparam logic [fwdWidth-1:0] fwdMem  = 2'd2;

endpackage

// File: rtl/idExRegister.sv
module idExRegister import corePkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   enable,
    input  logic [dataWidth-1:0]   pcD,
    input  logic [dataWidth-1:0]   pcPlus4D,
    input  logic                   regWriteD,
    input  logic [srcWidth-1:0]    resultSrcD,
    input  logic                   memWriteD,
    input  logic                   jumpD,
    input  logic                   branchD,
    input  logic [aluWidth-1:0]    aluControlD,
    input  logic                   aluSrcD,
    input  logic [dataWidth-1:0]   rd1D,
    input  logic [dataWidth-1:0]   rd2D,
    input  logic [regAddrWidth-1:0] rs1D,
    input  logic [regAddrWidth-1:0] rs2D,
    input  logic [regAddrWidth-1:0] rdD,
    input  logic [dataWidth-1:0]   extImmD,
    input  logic                   jalrD,
    input  logic [funct3Width-1:0] addressingControlD,
    output logic [dataWidth-1:0]   pcE,
    output logic [dataWidth-1:0]   pcPlus4E,
    output logic                   regWriteE,
    output logic [srcWidth-1:0]    resultSrcE,
    output logic                   memWriteE,
    output logic                   jumpE,
    output logic                   branchE,
    output logic [aluWidth-1:0]    aluControlE,
    output logic                   aluSrcE,
    output logic [dataWidth-1:0]   rd1E,
    output logic [dataWidth-1:0]   rd2E,
    output logic [regAddrWidth-1:0] rs1E,
    output logic [regAddrWidth-1:0] rs2E,
    output logic [regAddrWidth-1:0] rdE,
    output logic [dataWidth-1:0]   extImmE,
    output logic                   jalrE,
    output logic [funct3Width-1:0] addressingControlE
);

    // a flush turns the slot into a bubble, even while frozen.
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            pcE                <= '0;
            pcPlus4E           <= '0;
            regWriteE          <= 1'b0;
            resultSrcE         <= '0;
            memWriteE          <= 1'b0;
            jumpE              <= 1'b0;
            branchE            <= 1'b0;
            aluControlE        <= '0;
            aluSrcE            <= 1'b0;
            rd1E               <= '0;
            rd2E               <= '0;
            rs1E               <= '0;
            rs2E               <= '0;
            rdE                <= '0;
            extImmE            <= '0;
            jalrE              <= 1'b0;
            addressingControlE <= '0;
        end else if (enable) begin
            pcE                <= pcD;
            pcPlus4E           <= pcPlus4D;
            regWriteE          <= regWriteD;
            resultSrcE         <= resultSrcD;
            memWriteE          <= memWriteD;
            jumpE              <= jumpD;
            branchE            <= branchD;
            aluControlE        <= aluControlD;
            aluSrcE            <= aluSrcD;
            rd1E               <= rd1D;
            rd2E               <= rd2D;
            rs1E               <= rs1D;
            rs2E               <= rs2D;
            rdE                <= rdD;
            extImmE            <= extImmD;
            jalrE              <= jalrD;
            addressingControlE <= addressingControlD;
        end
    end

endmodule

// File: rtl/hazardUnit.sv
module hazardUnit import corePkg::*; (
    input  logic [regAddrWidth-1:0] rs1D,
    input  logic [regAddrWidth-1:0] rs2D,
    input  logic [regAddrWidth-1:0] rs1E,
    input  logic [regAddrWidth-1:0] rs2E,
    input  logic [regAddrWidth-1:0] rdE,
    input  logic [srcWidth-1:0]     resultSrcE,
    input  logic                    pcSrcE,
    input  logic [regAddrWidth-1:0] rdM,
    input  logic                    regWriteM,
    input  logic [regAddrWidth-1:0] rdW,
    input  logic                    regWriteW,
    input  logic                    memWait,
    output logic [fwdWidth-1:0]     forwardAE,
    output logic [fwdWidth-1:0]     forwardBE,
    output logic                    flushE,
    output logic                    enableE,
    output logic                    enableM,
    output logic                    stallD
);

    logic loadUse;

    // the memory stage wins over writeback, it is the younger result.
    function automatic logic [fwdWidth-1:0] pickForward(input logic [regAddrWidth-1:0] src);
        if (regWriteM && rdM != '0 && rdM == src)
            return fwdMem;
        else if (regWriteW && rdW != '0 && rdW == src)
            return fwdWb;
        return fwdNone;
    endfunction

    assign forwardAE = pickForward(rs1E);
    assign forwardBE = pickForward(rs2E);

    assign loadUse = resultSrcE == resultMem && rdE != '0 && (rdE == rs1D || rdE == rs2D);

    // a pending bus access freezes every stage, the flush waits for it.
    assign flushE  = (loadUse || pcSrcE) && !memWait;
    assign stallD  = loadUse || memWait;
    assign enableE = !memWait;
    assign enableM = !memWait;

endmodule

// File: rtl/executeUnit.sv
module executeUnit import corePkg::*; (
    input  logic [dataWidth-1:0]   rd1E,
    input  logic [dataWidth-1:0]   rd2E,
    input  logic [dataWidth-1:0]   extImmE,
    input  logic [dataWidth-1:0]   pcE,
    input  logic [dataWidth-1:0]   pcPlus4E,
    input  logic [aluWidth-1:0]    aluControlE,
    input  logic                   aluSrcE,
    input  logic                   jumpE,
    input  logic                   branchE,
    input  logic                   jalrE,
    input  logic [funct3Width-1:0] addressingControlE,
    input  logic [fwdWidth-1:0]    forwardAE,
    input  logic [fwdWidth-1:0]    forwardBE,
    input  logic [dataWidth-1:0]   aluResultM,
    input  logic [dataWidth-1:0]   resultW,
    output logic [dataWidth-1:0]   aluResultE,
    output logic [dataWidth-1:0]   writeDataE,
    output logic                   pcSrcE,
    output logic [dataWidth-1:0]   pcTargetE
);

    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] aluOut;
    logic                 taken;

    // ##############################
    // operand selection.
    always_comb begin
        case (forwardAE)
            fwdMem:  srcA = aluResultM;
            fwdWb:   srcA = resultW;
            default: srcA = rd1E;
        endcase
        case (forwardBE)
            fwdMem:  writeDataE = aluResultM;
            fwdWb:   writeDataE = resultW;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcB = aluSrcE ? extImmE : writeDataE;

    // ##############################
    // alu.
    always_comb begin
        case (aluControlE)
            aluAdd:   aluOut = srcA + srcB;
            aluSub:   aluOut = srcA - srcB;
            aluAnd:   aluOut = srcA & srcB;
            aluOr:    aluOut = srcA | srcB;
            aluXor:   aluOut = srcA ^ srcB;
            aluSll:   aluOut = srcA << srcB[4:0];
            aluSrl:   aluOut = srcA >> srcB[4:0];
            aluSra:   aluOut = $signed(srcA) >>> srcB[4:0];
            aluSlt:   aluOut = {{(dataWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluSltu:  aluOut = {{(dataWidth-1){1'b0}}, srcA < srcB};
            aluPassB: aluOut = srcB;
            default:  aluOut = '0;
        endcase
    end

    // a jump carries its link value so the memory stage can forward it.
    assign aluResultE = jumpE ? pcPlus4E : aluOut;

    // ##############################
    // branch and target.
    always_comb begin
        case (addressingControlE)
            beq:     taken = srcA == writeDataE;
            bne:     taken = srcA != writeDataE;
            blt:     taken = $signed(srcA) < $signed(writeDataE);
            bge:     taken = $signed(srcA) >= $signed(writeDataE);
            bltu:    taken = srcA < writeDataE;
            bgeu:    taken = srcA >= writeDataE;
            default: taken = 1'b0;
        endcase
    end

    assign pcSrcE    = jumpE || (branchE && taken);
    assign pcTargetE = jalrE ? ((srcA + extImmE) & ~{{(dataWidth-1){1'b0}}, 1'b1})
                             : pcE + extImmE;

endmodule

// File: rtl/memAccessCtrl.sv
module memAccessCtrl import corePkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  logic                    regWriteE,
    input  logic [srcWidth-1:0]     resultSrcE,
    input  logic                    memWriteE,
    input  logic [regAddrWidth-1:0] rdE,
    input  logic [dataWidth-1:0]    aluResultE,
    input  logic [dataWidth-1:0]    writeDataE,
    input  logic [dataWidth-1:0]    pcPlus4E,
    input  logic [funct3Width-1:0]  addressingControlE,
    input  logic [dataWidth-1:0]    wbDatIn,
    input  logic                    wbAck,
    output logic [dataWidth-1:0]    aluResultM,
    output logic [regAddrWidth-1:0] rdM,
    output logic                    regWriteM,
    output logic                    regWriteW,
    output logic [regAddrWidth-1:0] rdW,
    output logic [dataWidth-1:0]    resultW,
    output logic                    memWait,
    output logic                    wbCyc,
    output logic                    wbStb,
    output logic                    wbWe,
    output logic [dataWidth-1:0]    wbAdr,
    output logic [dataWidth-1:0]    wbDatOut,
    output logic [3:0]              wbSel
);

    localparam logic [1:0] stateIdle   = 2'd0;
    localparam logic [1:0] stateAccess = 2'd1;
    localparam logic [1:0] stateDone   = 2'd2;

    logic [1:0]             state;
    logic [srcWidth-1:0]    resultSrcM;
    logic                   memWriteM;
    logic [dataWidth-1:0]   writeDataM;
    logic [dataWidth-1:0]   pcPlus4M;
    logic [funct3Width-1:0] addressingControlM;
    logic                   memOpE;
    logic                   memOpM;
    logic [dataWidth-1:0]   laneData;
    logic [dataWidth-1:0]   loadData;

    assign memOpE = memWriteE || resultSrcE == resultMem;
    assign memOpM = memWriteM || resultSrcM == resultMem;

    // ##############################
    // execute/memory register.
    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM  <= 1'b0;
            resultSrcM <= resultAlu;
            memWriteM  <= 1'b0;
        end else if (enable) begin
            regWriteM  <= regWriteE;
            resultSrcM <= resultSrcE;
            memWriteM  <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            rdM                <= rdE;
            aluResultM         <= aluResultE;
            writeDataM         <= writeDataE;
            pcPlus4M           <= pcPlus4E;
            addressingControlM <= addressingControlE;
        end
    end

    // ##############################
    // bus FSM. done drops cyc for one cycle before a back-to-back access.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateIdle;
        end else begin
            case (state)
                stateAccess: if (wbAck) state <= stateDone;
                stateDone:   state <= (memOpM || memOpE) ? stateAccess : stateIdle;
                default:     state <= memOpE ? stateAccess : stateIdle;
            endcase
        end
    end

    // in done with a memory op in M, the access has not started yet.
    assign memWait = (state == stateAccess && !wbAck) || (state == stateDone && memOpM);

    assign wbCyc = state == stateAccess;
    assign wbStb = state == stateAccess;
    assign wbWe  = memWriteM;
    assign wbAdr = {aluResultM[dataWidth-1:2], 2'b00};

    always_comb begin
        case (addressingControlM)
            sizeByte: begin
                wbDatOut = {4{writeDataM[7:0]}};
                wbSel    = 4'b0001 << aluResultM[1:0];
            end
            sizeHalf: begin
                wbDatOut = {2{writeDataM[15:0]}};
                wbSel    = aluResultM[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wbDatOut = writeDataM;
                wbSel    = 4'b1111;
            end
        endcase
    end

    // load lane extraction.
    assign laneData = wbDatIn >> {aluResultM[1:0], 3'b000};

    always_comb begin
        case (addressingControlM)
            sizeByte:  loadData = {{(dataWidth-8){laneData[7]}}, laneData[7:0]};
            sizeHalf:  loadData = {{(dataWidth-16){laneData[15]}}, laneData[15:0]};
            sizeByteU: loadData = {{(dataWidth-8){1'b0}}, laneData[7:0]};
            sizeHalfU: loadData = {{(dataWidth-16){1'b0}}, laneData[15:0]};
            sizeWord:  loadData = wbDatIn;
            default:   loadData = wbDatIn;
        endcase
    end

    // ##############################
    // memory/writeback register, a bubble while the bus waits.
    always_ff @(posedge clk) begin
        if (reset)
            regWriteW <= 1'b0;
        else
            regWriteW <= enable && regWriteM;
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            rdW <= rdM;
            case (resultSrcM)
                resultMem:     resultW <= loadData;
                resultPcPlus4: resultW <= pcPlus4M;
                default:       resultW <= aluResultM;
            endcase
        end
    end

endmodule

// File: rtl/exMemTop.sv
module exMemTop import corePkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [dataWidth-1:0]    pcD,
    input  logic [dataWidth-1:0]    pcPlus4D,
    input  logic                    regWriteD,
    input  logic [srcWidth-1:0]     resultSrcD,
    input  logic                    memWriteD,
    input  logic                    jumpD,
    input  logic                    branchD,
    input  logic [aluWidth-1:0]     aluControlD,
    input  logic                    aluSrcD,
    input  logic [dataWidth-1:0]    rd1D,
    input  logic [dataWidth-1:0]    rd2D,
    input  logic [regAddrWidth-1:0] rs1D,
    input  logic [regAddrWidth-1:0] rs2D,
    input  logic [regAddrWidth-1:0] rdD,
    input  logic [dataWidth-1:0]    extImmD,
    input  logic                    jalrD,
    input  logic [funct3Width-1:0]  addressingControlD,
    output logic                    regWriteW,
    output logic [regAddrWidth-1:0] rdW,
    output logic [dataWidth-1:0]    resultW,
    output logic                    pcSrcE,
    output logic [dataWidth-1:0]    pcTargetE,
    output logic                    stallD,
    output logic                    wbCyc,
    output logic                    wbStb,
    output logic                    wbWe,
    output logic [dataWidth-1:0]    wbAdr,
    output logic [dataWidth-1:0]    wbDatOut,
    output logic [3:0]              wbSel,
    input  logic [dataWidth-1:0]    wbDatIn,
    input  logic                    wbAck
);

    logic [dataWidth-1:0]    pcE, pcPlus4E, rd1E, rd2E, extImmE;
    logic [dataWidth-1:0]    aluResultE, writeDataE, aluResultM;
    logic                    regWriteE, memWriteE, jumpE, branchE, aluSrcE, jalrE;
    logic [srcWidth-1:0]     resultSrcE;
    logic [aluWidth-1:0]     aluControlE;
    logic [regAddrWidth-1:0] rs1E, rs2E, rdE, rdM;
    logic [funct3Width-1:0]  addressingControlE;
    logic [fwdWidth-1:0]     forwardAE, forwardBE;
    logic                    regWriteM, memWait, flushE, enableE, enableM;

    idExRegister idEx0 (.clk, .reset, .flush(flushE), .enable(enableE), .*);

    hazardUnit hazard0 (.*);

    executeUnit execute0 (.*);

    memAccessCtrl mem0 (.clk, .reset, .enable(enableM), .*);

endmodule

// File: dv/wbMaster_props.sv
module wbMaster_props import corePkg::*; (
    input logic                 clk,
    input logic                 reset,
    input logic                 wbCyc,
    input logic                 wbStb,
    input logic                 wbWe,
    input logic                 wbAck,
    input logic [dataWidth-1:0] wbAdr,
    input logic [dataWidth-1:0] wbDatOut,
    input logic [3:0]           wbSel
);
    timeunit 1ns;
    timeprecision 1ps;

    // one transfer per cycle of ack.
    ackInRequest: assert property (@(posedge clk) disable iff (reset)
        wbAck |-> wbCyc && wbStb)
        else $error("wishbone ack without a live request");

    // request held until ack.
    heldUntilAck: assert property (@(posedge clk) disable iff (reset)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbSel)
                            && $stable(wbDatOut))
        else $error("wishbone request changed before ack");

    cycEndsAfterAck: assert property (@(posedge clk) disable iff (reset)
        wbCyc && wbAck |=> !wbCyc)
        else $error("wishbone cyc still high after ack");

endmodule

bind memAccessCtrl wbMaster_props props0 (
    .clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAck(wbAck),
    .wbAdr(wbAdr), .wbDatOut(wbDatOut), .wbSel(wbSel)
);

// File: dv/exMemTb.sv
module exMemTb import corePkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int stride      = 21;
    localparam int memBase     = 'h300;
    localparam int resetCycles = 10;

    logic clk = 1'b0;
    logic reset;
    logic [dataWidth-1:0] pcD, pcPlus4D, rd1D, rd2D, extImmD;
    logic regWriteD, memWriteD, jumpD, branchD, aluSrcD, jalrD;
    logic [srcWidth-1:0] resultSrcD;
    logic [aluWidth-1:0] aluControlD;
    logic [regAddrWidth-1:0] rs1D, rs2D, rdD;
    logic [funct3Width-1:0] addressingControlD;
    logic regWriteW, pcSrcE, stallD, wbCyc, wbStb, wbWe;
    logic [regAddrWidth-1:0] rdW;
    logic [dataWidth-1:0] resultW, pcTargetE, wbAdr, wbDatOut;
    logic [3:0] wbSel;
    logic [dataWidth-1:0] wbDatIn = '0;
    logic wbAck = 1'b0;

    logic [31:0] image [0:1023];
    logic [31:0] memWords [0:15];
    int recCount;
    int errors = 0;
    int cycles = 0;
    int limit = 0;
    int seed = 18450;
    int waitLeft = 0;
    int pendIdx[$];
    logic [31:0] pendRd[$];
    logic [dataWidth-1:0] pendVal[$];

    exMemTop dut0 (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] recordWord(input int k, input int col);
        return image[1 + k * stride + col];
    endfunction

    function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] sel);
        logic [31:0] word;
        word = old;
        for (int i = 0; i < 4; i++)
            if (sel[i]) word[8*i +: 8] = data[8*i +: 8];
        return word;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finishRun(input bit timedOut);
        $display("errors %0d, timeouts %0d", errors, timedOut);
        if (errors == 0 && !timedOut)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    // ##############################
    // decode side.
    task automatic driveBubble();
        pcD <= '0;
        pcPlus4D <= '0;
        {regWriteD, memWriteD, jumpD, branchD, aluSrcD, jalrD} <= '0;
        resultSrcD <= '0;
        aluControlD <= '0;
        {rd1D, rd2D, extImmD} <= '0;
        {rs1D, rs2D, rdD} <= '0;
        addressingControlD <= '0;
    endtask

    task automatic driveRecord(input int k);
        logic [31:0] r [0:stride-1];
        for (int c = 0; c < stride; c++)
            r[c] = recordWord(k, c);
        pcD <= r[0];
        pcPlus4D <= r[0] + 32'd4;
        regWriteD <= r[1][0];
        resultSrcD <= r[2][1:0];
        memWriteD <= r[3][0];
        jumpD <= r[4][0];
        branchD <= r[5][0];
        aluControlD <= r[6][3:0];
        aluSrcD <= r[7][0];
        jalrD <= r[8][0];
        addressingControlD <= r[9][2:0];
        rd1D <= r[10];
        rd2D <= r[11];
        rs1D <= r[12][4:0];
        rs2D <= r[13][4:0];
        rdD <= r[14][4:0];
        extImmD <= r[15];
    endtask

    // redirect is combinational from the execute register.
    task automatic checkRedirect(input int k);
        checkValue($sformatf("record %0d pcSrc", k), recordWord(k, 19), {31'b0, pcSrcE});
        if (recordWord(k, 19) == 1)
            checkValue($sformatf("record %0d target", k), recordWord(k, 20), pcTargetE);
    endtask

    // ##############################
    // wishbone memory with random ack delay.
    always @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
            for (int i = 0; i < 16; i++)
                memWords[i] <= image[memBase + i];
        end else if (wbAck) begin
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (waitLeft == 0) begin
                wbAck <= 1'b1;
                if (wbWe)
                    memWords[wbAdr[5:2]] <= mergeLanes(memWords[wbAdr[5:2]], wbDatOut, wbSel);
                else
                    wbDatIn <= memWords[wbAdr[5:2]];
                waitLeft = $unsigned($random(seed)) % 4;
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

    // writebacks leave in issue order.
    always @(negedge clk) begin
        int idx;
        if (!reset && regWriteW) begin
            if (pendRd.size() == 0) begin
                errors++;
                $display("writeback to register %0d that no instruction expects", rdW);
            end else begin
                idx = pendIdx.pop_front();
                checkValue($sformatf("record %0d rd", idx), pendRd.pop_front(),
                           {27'b0, rdW});
                checkValue($sformatf("record %0d result", idx), pendVal.pop_front(), resultW);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles with %0d writebacks pending",
                     cycles, pendRd.size());
            finishRun(1'b1);
        end
    end

    initial begin
        $readmemh("dv/exMem_input.txt", image);
        recCount = image[0];
        limit = 8 * recCount + resetCycles;
        driveBubble();
        reset <= 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkValue("reset state", '0, {26'b0, wbCyc, wbStb, wbWe, regWriteW, pcSrcE, stallD});
        @(posedge clk);
        for (int k = 0; k < recCount; k++) begin
            driveRecord(k);
            @(negedge clk);
            if (k > 0) checkRedirect(k - 1);
            while (stallD) @(negedge clk);
            @(posedge clk);
            if (recordWord(k, 16) == 1) begin
                pendIdx.push_back(k);
                pendRd.push_back(recordWord(k, 17));
                pendVal.push_back(recordWord(k, 18));
            end
        end
        driveBubble();
        @(negedge clk);
        checkRedirect(recCount - 1);
        while (pendRd.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        finishRun(1'b0);
    end

endmodule

// File: dv/exMem_input.txt
// word 0 is the record count, then one record per line, hex columns:
// pc regWrite resultSrc memWrite jump branch aluCtl aluSrc jalr funct3 rd1 rd2 rs1 rs2 rd imm
// then expWrite expRd expValue expPcSrc expTarget
1e
40 1 0 0 0 0 0 1 0 0 10 0 2 0 1 5 1 1 15 0 0
44 1 0 0 0 0 1 0 0 0 0 3 1 4 3 0 1 3 12 0 0
48 1 0 0 0 0 4 0 0 0 0 0 1 3 5 0 1 5 7 0 0
4c 1 0 0 0 0 5 1 0 0 0 0 5 0 6 4 1 6 70 0 0
50 1 0 0 0 0 7 0 0 0 80000000 4 8 9 7 0 1 7 f8000000 0 0
54 1 0 0 0 0 6 0 0 0 80000000 4 8 9 a 0 1 a 8000000 0 0
58 1 0 0 0 0 8 0 0 0 f8000000 70 7 6 b 0 1 b 1 0 0
64 1 0 0 0 0 a 1 0 0 0 0 0 0 e 100 1 e 100 0 0
68 0 0 1 0 0 0 1 0 2 0 13572468 e f 0 8 0 0 0 0 0
6c 0 0 1 0 0 0 1 0 0 100 ee e 10 0 d 0 0 0 0 0
70 0 0 1 0 0 0 1 0 1 100 beef e 11 0 12 0 0 0 0 0
74 1 1 0 0 0 0 1 0 2 100 0 e 0 12 8 1 12 13572468 0 0
78 1 1 0 0 0 0 1 0 0 100 0 e 0 13 d 1 13 ffffffee 0 0
7c 1 1 0 0 0 0 1 0 4 100 0 e 0 14 d 1 14 ee 0 0
80 1 1 0 0 0 0 1 0 1 100 0 e 0 15 12 1 15 ffffbeef 0 0
84 1 1 0 0 0 0 1 0 5 100 0 e 0 16 12 1 16 beef 0 0
88 1 1 0 0 0 0 1 0 1 100 0 e 0 17 2 1 17 ffff80ff 0 0
8c 1 1 0 0 0 0 1 0 2 100 0 e 0 18 4 1 18 12345678 0 0
90 1 0 0 0 0 0 0 0 0 0 ffff80ff 18 17 19 0 1 19 1233d777 0 0
94 0 0 0 0 1 1 0 0 0 0 0 19 1a 0 40 0 0 0 0 0
98 0 0 0 0 1 1 0 0 1 0 0 19 0 0 20 0 0 0 1 b8
9c 1 0 0 0 0 0 1 0 0 5 0 0 0 1b 1 0 0 0 0 0
b8 0 0 0 0 1 1 0 0 4 f8000000 70 7 6 0 fffffff8 0 0 0 1 b0
bc 1 0 0 0 0 0 1 0 0 5 0 0 0 1b 1 0 0 0 0 0
b0 0 0 0 0 1 1 0 0 6 f8000000 70 7 6 0 40 0 0 0 0 0
b4 1 2 0 1 0 0 0 0 0 0 0 0 0 1 100 1 1 b8 1 1b4
b8 1 0 0 0 0 0 1 0 0 5 0 0 0 1b 1 0 0 0 0 0
1b4 1 2 0 1 0 0 1 1 0 0 0 1 0 5 11 1 5 1b8 1 c8
1b8 1 0 0 0 0 0 1 0 0 5 0 0 0 1b 1 0 0 0 0 0
c8 1 0 0 0 0 0 0 0 0 0 0 5 0 1c 0 1 1c 1b8 0 0
// memory image, word index from address bits 5:2.
@300
80ff7f01 12345678 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: src.f
rtl/corePkg.sv
rtl/idExRegister.sv
rtl/hazardUnit.sv
rtl/executeUnit.sv
rtl/memAccessCtrl.sv
rtl/exMemTop.sv
dv/wbMaster_props.sv
dv/exMemTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module exMemTb \
    -Mdir obj_dir -o exMemSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/exMemSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1
